// File: logic/decoder.sv
`default_nettype none
`timescale 1ns/100ps

module decoder (
  input  logic [pipe_pkg::XLEN-1:0]        instr,
  output logic [rv_isa_pkg::REG_IDX_W-1:0] rs1,
  output logic [rv_isa_pkg::REG_IDX_W-1:0] rs2,
  output logic [rv_isa_pkg::REG_IDX_W-1:0] rd,
  output logic [pipe_pkg::XLEN-1:0]        imm,
  output pipe_pkg::alu_op_t                alu_op,
  output logic                             alu_src_imm,
  output logic                             reg_write,
  output logic                             mem_write,
  output logic                             mem_read,
  output logic                             branch,
  output logic                             branch_ne,
  output logic                             jump,
  output pipe_pkg::result_sel_t            result_sel
);

  logic [6:0]            opcode;
  logic [2:0]            funct3;
  logic                  sub_bit;
  pipe_pkg::alu_op_t     f3_op;
  rv_isa_pkg::imm_kind_t imm_kind;

  assign opcode  = instr[6:0];
  assign funct3  = instr[rv_isa_pkg::F3_LSB +: 3];
  assign sub_bit = instr[rv_isa_pkg::F7_LSB + rv_isa_pkg::F7_SUB_BIT];
  assign rs1     = instr[rv_isa_pkg::RS1_LSB +: rv_isa_pkg::REG_IDX_W];
  assign rs2     = instr[rv_isa_pkg::RS2_LSB +: rv_isa_pkg::REG_IDX_W];
  assign rd      = instr[rv_isa_pkg::RD_LSB +: rv_isa_pkg::REG_IDX_W];

  // sub only exists in register form
  always_comb begin
    case (funct3)
      rv_isa_pkg::F3_ADD: begin
        f3_op = (opcode == rv_isa_pkg::OP_REG && sub_bit) ? pipe_pkg::ALU_SUB : pipe_pkg::ALU_ADD;
      end
      rv_isa_pkg::F3_SLL: f3_op = pipe_pkg::ALU_SLL;
      rv_isa_pkg::F3_SLT: f3_op = pipe_pkg::ALU_SLT;
      rv_isa_pkg::F3_XOR: f3_op = pipe_pkg::ALU_XOR;
      rv_isa_pkg::F3_SRL: f3_op = pipe_pkg::ALU_SRL;
      rv_isa_pkg::F3_OR:  f3_op = pipe_pkg::ALU_OR;
      rv_isa_pkg::F3_AND: f3_op = pipe_pkg::ALU_AND;
      default:            f3_op = pipe_pkg::ALU_ADD;
    endcase
  end

  always_comb begin
    alu_op      = pipe_pkg::ALU_ADD;
    alu_src_imm = 1'b0;
    reg_write   = 1'b0;
    mem_write   = 1'b0;
    mem_read    = 1'b0;
    branch      = 1'b0;
    branch_ne   = 1'b0;
    jump        = 1'b0;
    result_sel  = pipe_pkg::RES_ALU;
    imm_kind    = rv_isa_pkg::IMM_I;
    case (opcode)
      rv_isa_pkg::OP_REG: begin
        reg_write = 1'b1;
        alu_op    = f3_op;
      end
      rv_isa_pkg::OP_IMM: begin
        reg_write   = 1'b1;
        alu_src_imm = 1'b1;
        alu_op      = f3_op;
      end
      rv_isa_pkg::OP_LUI: begin
        reg_write   = 1'b1;
        alu_src_imm = 1'b1;
        alu_op      = pipe_pkg::ALU_PASS_B;
        imm_kind    = rv_isa_pkg::IMM_U;
      end
      rv_isa_pkg::OP_LOAD: begin
        if (funct3 == rv_isa_pkg::F3_WORD) begin
          reg_write   = 1'b1;
          mem_read    = 1'b1;
          alu_src_imm = 1'b1;
          result_sel  = pipe_pkg::RES_MEM;
        end
      end
      rv_isa_pkg::OP_STORE: begin
        if (funct3 == rv_isa_pkg::F3_WORD) begin
          mem_write   = 1'b1;
          alu_src_imm = 1'b1;
          imm_kind    = rv_isa_pkg::IMM_S;
        end
      end
      rv_isa_pkg::OP_BRANCH: begin
        if (funct3 == rv_isa_pkg::F3_BEQ || funct3 == rv_isa_pkg::F3_BNE) begin
          branch    = 1'b1;
          branch_ne = funct3 == rv_isa_pkg::F3_BNE;
          imm_kind  = rv_isa_pkg::IMM_B;
        end
      end
      rv_isa_pkg::OP_JAL: begin
        reg_write  = 1'b1;
        jump       = 1'b1;
        result_sel = pipe_pkg::RES_LINK;
        imm_kind   = rv_isa_pkg::IMM_J;
      end
      default: begin
      end
    endcase
  end

  always_comb begin
    case (imm_kind)
      rv_isa_pkg::IMM_S: imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
      rv_isa_pkg::IMM_B: imm = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
      rv_isa_pkg::IMM_J: imm = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
      rv_isa_pkg::IMM_U: imm = {instr[31:12], 12'b0};
      default:           imm = {{20{instr[31]}}, instr[31:20]};
    endcase
  end

endmodule

`default_nettype wire

// File: logic/execute_unit.sv
`default_nettype none
`timescale 1ns/100ps

module execute_unit (
  input  logic [pipe_pkg::XLEN-1:0] rd1,
  input  logic [pipe_pkg::XLEN-1:0] rd2,
  input  logic [pipe_pkg::XLEN-1:0] imm,
  input  logic [pipe_pkg::XLEN-1:0] pc,
  input  logic [pipe_pkg::XLEN-1:0] pc_plus4,
  input  logic [pipe_pkg::XLEN-1:0] alu_result_m,
  input  logic [pipe_pkg::XLEN-1:0] link_m,
  input  logic [pipe_pkg::XLEN-1:0] result_w,
  input  pipe_pkg::fwd_sel_t        fwd_a,
  input  pipe_pkg::fwd_sel_t        fwd_b,
  input  pipe_pkg::alu_op_t         alu_op,
  input  logic                      alu_src_imm,
  input  logic                      branch,
  input  logic                      branch_ne,
  input  logic                      jump,
  input  logic                      predict_taken,
  output logic [pipe_pkg::XLEN-1:0] alu_result,
  output logic [pipe_pkg::XLEN-1:0] store_data,
  output logic [pipe_pkg::XLEN-1:0] redirect_pc,
  output logic                      mispredict,
  output logic                      resolve_valid,
  output logic                      resolve_taken
);

  logic [pipe_pkg::XLEN-1:0] src_a;
  logic [pipe_pkg::XLEN-1:0] src_b;
  logic                      taken;

  function automatic logic [pipe_pkg::XLEN-1:0] fwd_mux(input pipe_pkg::fwd_sel_t sel,
                                                        input logic [pipe_pkg::XLEN-1:0] reg_val);
    case (sel)
      pipe_pkg::FWD_W:      return result_w;
      pipe_pkg::FWD_M_ALU:  return alu_result_m;
      pipe_pkg::FWD_M_LINK: return link_m;
      default:              return reg_val;
    endcase
  endfunction

  assign src_a      = fwd_mux(fwd_a, rd1);
  assign store_data = fwd_mux(fwd_b, rd2);
  assign src_b      = alu_src_imm ? imm : store_data;

  always_comb begin
    case (alu_op)
      pipe_pkg::ALU_SUB:    alu_result = src_a - src_b;
      pipe_pkg::ALU_AND:    alu_result = src_a & src_b;
      pipe_pkg::ALU_OR:     alu_result = src_a | src_b;
      pipe_pkg::ALU_XOR:    alu_result = src_a ^ src_b;
      pipe_pkg::ALU_SLT:    alu_result = {31'b0, $signed(src_a) < $signed(src_b)};
      pipe_pkg::ALU_SLL:    alu_result = src_a << src_b[4:0];
      pipe_pkg::ALU_SRL:    alu_result = src_a >> src_b[4:0];
      pipe_pkg::ALU_PASS_B: alu_result = src_b;
      default:              alu_result = src_a + src_b;
    endcase
  end

  // branches compare the two register operands, not the ALU result
  assign taken = jump || (branch && ((src_a == store_data) ^ branch_ne));

  assign mispredict    = (branch || jump) && (taken != predict_taken);
  assign redirect_pc   = taken ? pc + imm : pc_plus4;
  assign resolve_valid = branch;
  assign resolve_taken = taken;

endmodule

`default_nettype wire

// File: logic/fetch_unit.sv
`default_nettype none
`timescale 1ns/100ps

module fetch_unit (
  input  logic                      clk,
  input  logic                      rstn,
  input  logic                      stall,
  input  logic                      mispredict,
  input  logic [pipe_pkg::XLEN-1:0] redirect_pc,
  input  logic                      resolve_valid,
  input  logic                      resolve_taken,
  input  logic [pipe_pkg::XLEN-1:0] instr,
  output logic [pipe_pkg::XLEN-1:0] pc,
  output logic [pipe_pkg::XLEN-1:0] pc_plus4,
  output logic                      predict_taken
);

  logic [pipe_pkg::XLEN-1:0]   next_pc;
  logic [pipe_pkg::XLEN-1:0]   jal_target;
  logic [pipe_pkg::XLEN-1:0]   br_target;
  logic [pipe_pkg::PRED_W-1:0] counter;
  logic                        is_jal;
  logic                        is_branch;

  assign is_jal    = instr[6:0] == rv_isa_pkg::OP_JAL;
  assign is_branch = instr[6:0] == rv_isa_pkg::OP_BRANCH;

  assign jal_target = pc + {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
  assign br_target  = pc + {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
  assign pc_plus4   = pc + 32'd4;

  // jal counts as predicted taken so E never sees it as a mispredict
  assign predict_taken = is_jal || (is_branch && counter[pipe_pkg::PRED_W-1]);

  always_comb begin
    if (mispredict) begin
      next_pc = redirect_pc;
    end else if (is_jal) begin
      next_pc = jal_target;
    end else if (predict_taken) begin
      next_pc = br_target;
    end else begin
      next_pc = pc_plus4;
    end
  end

  always_ff @(posedge clk) begin
    if (!rstn) begin
      pc <= pipe_pkg::RESET_PC;
    end else if (!stall || mispredict) begin
      pc <= next_pc;
    end
  end

  // saturating counter, starts strongly taken
  always_ff @(posedge clk) begin
    if (!rstn) begin
      counter <= '1;
    end else if (resolve_valid) begin
      if (resolve_taken && counter != '1) begin
        counter <= counter + 1'b1;
      end else if (!resolve_taken && counter != '0) begin
        counter <= counter - 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// File: logic/hazard_unit.sv
`default_nettype none
`timescale 1ns/100ps

module hazard_unit (
  input  logic [rv_isa_pkg::REG_IDX_W-1:0] rs1_d,
  input  logic [rv_isa_pkg::REG_IDX_W-1:0] rs2_d,
  input  logic [rv_isa_pkg::REG_IDX_W-1:0] rs1_e,
  input  logic [rv_isa_pkg::REG_IDX_W-1:0] rs2_e,
  input  logic [rv_isa_pkg::REG_IDX_W-1:0] rd_e,
  input  logic [rv_isa_pkg::REG_IDX_W-1:0] rd_m,
  input  logic [rv_isa_pkg::REG_IDX_W-1:0] rd_w,
  input  logic                             mem_read_e,
  input  logic                             reg_write_m,
  input  logic                             reg_write_w,
  input  pipe_pkg::result_sel_t            result_sel_m,
  input  logic                             mispredict,
  input  logic                             data_stall,
  output logic                             stall_f,
  output logic                             stall_d,
  output logic                             en_e,
  output logic                             en_m,
  output logic                             en_w,
  output logic                             flush_d,
  output logic                             flush_e,
  output pipe_pkg::fwd_sel_t               fwd_a,
  output pipe_pkg::fwd_sel_t               fwd_b
);

  logic load_use;

  // M has priority, being the younger write
  function automatic pipe_pkg::fwd_sel_t fwd_for(input logic [rv_isa_pkg::REG_IDX_W-1:0] rs);
    if (rs != '0 && reg_write_m && rs == rd_m) begin
      return (result_sel_m == pipe_pkg::RES_LINK) ? pipe_pkg::FWD_M_LINK : pipe_pkg::FWD_M_ALU;
    end else if (rs != '0 && reg_write_w && rs == rd_w) begin
      return pipe_pkg::FWD_W;
    end
    return pipe_pkg::FWD_REG;
  endfunction

  assign fwd_a = fwd_for(rs1_e);
  assign fwd_b = fwd_for(rs2_e);

  assign load_use = mem_read_e && rd_e != '0 && (rd_e == rs1_d || rd_e == rs2_d);

  assign stall_f = load_use || data_stall;
  assign stall_d = load_use || data_stall;
  assign en_e    = !data_stall;
  assign en_m    = !data_stall;
  assign en_w    = !data_stall;
  assign flush_d = mispredict && !data_stall;
  assign flush_e = (mispredict || load_use) && !data_stall;

endmodule

`default_nettype wire

// File: logic/pipe_core.sv
`default_nettype none
`timescale 1ns/100ps

module pipe_core (
  input  logic                      clk,
  input  logic                      rstn,
  output logic [pipe_pkg::XLEN-1:0] imem_addr,
  input  logic [pipe_pkg::XLEN-1:0] imem_data,
  output logic [pipe_pkg::XLEN-1:0] dmem_addr,
  output logic [pipe_pkg::XLEN-1:0] dmem_wdata,
  output logic                      dmem_we,
  output logic                      dmem_re,
  input  logic [pipe_pkg::XLEN-1:0] dmem_rdata,
  input  logic                      data_stall
);

  pipe_pkg::fd_t fd_d, fd_q;
  pipe_pkg::de_t de_d, de_q;
  pipe_pkg::em_t em_d, em_q;
  pipe_pkg::mw_t mw_d, mw_q;

  logic [pipe_pkg::XLEN-1:0] pc_plus4_f;
  logic                      predict_f;
  logic stall_f, stall_d, en_e, en_m, en_w, flush_d, flush_e;
  pipe_pkg::fwd_sel_t fwd_a, fwd_b;

  logic [pipe_pkg::XLEN-1:0] alu_result_e, store_data_e, redirect_pc, result_w;
  logic mispredict, resolve_valid, resolve_taken;

  fetch_unit u_fetch (
    .clk(clk), .rstn(rstn), .stall(stall_f),
    // flush_d is the mispredict with the freeze taken out
    .mispredict(flush_d), .redirect_pc(redirect_pc),
    .resolve_valid(resolve_valid && en_e), .resolve_taken(resolve_taken),
    .instr(imem_data), .pc(imem_addr), .pc_plus4(pc_plus4_f), .predict_taken(predict_f)
  );

  assign fd_d = '{instr: imem_data, pc: imem_addr, pc_plus4: pc_plus4_f,
                  predict_taken: predict_f};

  stage_reg #(.payload_t(pipe_pkg::fd_t)) u_fd (
    .clk(clk), .rstn(rstn), .en(!stall_d), .clr(flush_d), .d(fd_d), .q(fd_q)
  );

  decoder u_dec (
    .instr(fd_q.instr), .rs1(de_d.rs1), .rs2(de_d.rs2), .rd(de_d.rd), .imm(de_d.imm),
    .alu_op(de_d.alu_op), .alu_src_imm(de_d.alu_src_imm), .reg_write(de_d.reg_write),
    .mem_write(de_d.mem_write), .mem_read(de_d.mem_read), .branch(de_d.branch),
    .branch_ne(de_d.branch_ne), .jump(de_d.jump), .result_sel(de_d.result_sel)
  );

  register_file u_rf (
    .clk(clk), .rstn(rstn), .we(mw_q.reg_write), .waddr(mw_q.rd), .wdata(result_w),
    .raddr1(de_d.rs1), .raddr2(de_d.rs2), .rdata1(de_d.rd1), .rdata2(de_d.rd2)
  );

  assign de_d.pc            = fd_q.pc;
  assign de_d.pc_plus4      = fd_q.pc_plus4;
  assign de_d.predict_taken = fd_q.predict_taken;

  stage_reg #(.payload_t(pipe_pkg::de_t)) u_de (
    .clk(clk), .rstn(rstn), .en(en_e), .clr(flush_e), .d(de_d), .q(de_q)
  );

  hazard_unit u_hazard (
    .rs1_d(de_d.rs1), .rs2_d(de_d.rs2), .rs1_e(de_q.rs1), .rs2_e(de_q.rs2),
    .rd_e(de_q.rd), .rd_m(em_q.rd), .rd_w(mw_q.rd), .mem_read_e(de_q.mem_read),
    .reg_write_m(em_q.reg_write), .reg_write_w(mw_q.reg_write),
    .result_sel_m(em_q.result_sel), .mispredict(mispredict), .data_stall(data_stall),
    .stall_f(stall_f), .stall_d(stall_d), .en_e(en_e), .en_m(en_m), .en_w(en_w),
    .flush_d(flush_d), .flush_e(flush_e), .fwd_a(fwd_a), .fwd_b(fwd_b)
  );

  execute_unit u_exec (
    .rd1(de_q.rd1), .rd2(de_q.rd2), .imm(de_q.imm), .pc(de_q.pc), .pc_plus4(de_q.pc_plus4),
    .alu_result_m(em_q.alu_result), .link_m(em_q.pc_plus4), .result_w(result_w),
    .fwd_a(fwd_a), .fwd_b(fwd_b), .alu_op(de_q.alu_op), .alu_src_imm(de_q.alu_src_imm),
    .branch(de_q.branch), .branch_ne(de_q.branch_ne), .jump(de_q.jump),
    .predict_taken(de_q.predict_taken), .alu_result(alu_result_e),
    .store_data(store_data_e), .redirect_pc(redirect_pc), .mispredict(mispredict),
    .resolve_valid(resolve_valid), .resolve_taken(resolve_taken)
  );

  assign em_d = '{alu_result: alu_result_e, store_data: store_data_e, rd: de_q.rd,
                  pc_plus4: de_q.pc_plus4, reg_write: de_q.reg_write,
                  mem_write: de_q.mem_write, mem_read: de_q.mem_read,
                  result_sel: de_q.result_sel};

  stage_reg #(.payload_t(pipe_pkg::em_t)) u_em (
    .clk(clk), .rstn(rstn), .en(en_m), .clr(1'b0), .d(em_d), .q(em_q)
  );

  assign dmem_addr  = em_q.alu_result;
  assign dmem_wdata = em_q.store_data;
  assign dmem_we    = em_q.mem_write;
  assign dmem_re    = em_q.mem_read;

  assign mw_d = '{alu_result: em_q.alu_result, load_data: dmem_rdata, rd: em_q.rd,
                  pc_plus4: em_q.pc_plus4, reg_write: em_q.reg_write,
                  result_sel: em_q.result_sel};

  stage_reg #(.payload_t(pipe_pkg::mw_t)) u_mw (
    .clk(clk), .rstn(rstn), .en(en_w), .clr(1'b0), .d(mw_d), .q(mw_q)
  );

  always_comb begin
    case (mw_q.result_sel)
      pipe_pkg::RES_MEM:  result_w = mw_q.load_data;
      pipe_pkg::RES_LINK: result_w = mw_q.pc_plus4;
      default:            result_w = mw_q.alu_result;
    endcase
  end

endmodule

`default_nettype wire

// File: logic/pipe_pkg.sv
`default_nettype none

package pipe_pkg;

  localparam int XLEN   = 32;
  localparam int PRED_W = 2;

  localparam logic [XLEN-1:0] RESET_PC = '0;

  // pass-b carries the lui immediate
  typedef enum logic [3:0] {
    ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR,
    ALU_SLT, ALU_SLL, ALU_SRL, ALU_PASS_B
  } alu_op_t;

  typedef enum logic [1:0] {RES_ALU, RES_MEM, RES_LINK} result_sel_t;

  typedef enum logic [1:0] {FWD_REG, FWD_W, FWD_M_ALU, FWD_M_LINK} fwd_sel_t;

  typedef struct packed {
    logic [XLEN-1:0] instr;
    logic [XLEN-1:0] pc;
    logic [XLEN-1:0] pc_plus4;
    logic            predict_taken;
  } fd_t;

  typedef struct packed {
    alu_op_t         alu_op;
    logic            alu_src_imm;
    logic            reg_write;
    logic            mem_write;
    logic            mem_read;
    logic            branch;
    logic            branch_ne;
    logic            jump;
    result_sel_t     result_sel;
    logic [rv_isa_pkg::REG_IDX_W-1:0] rs1;
    logic [rv_isa_pkg::REG_IDX_W-1:0] rs2;
    logic [rv_isa_pkg::REG_IDX_W-1:0] rd;
    logic [XLEN-1:0] rd1;
    logic [XLEN-1:0] rd2;
    logic [XLEN-1:0] imm;
    logic [XLEN-1:0] pc;
    logic [XLEN-1:0] pc_plus4;
    logic            predict_taken;
  } de_t;

  typedef struct packed {
    logic [XLEN-1:0] alu_result;
    logic [XLEN-1:0] store_data;
    logic [rv_isa_pkg::REG_IDX_W-1:0] rd;
    logic [XLEN-1:0] pc_plus4;
    logic            reg_write;
    logic            mem_write;
    logic            mem_read;
    result_sel_t     result_sel;
  } em_t;

  typedef struct packed {
    logic [XLEN-1:0] alu_result;
    logic [XLEN-1:0] load_data;
    logic [rv_isa_pkg::REG_IDX_W-1:0] rd;
    logic [XLEN-1:0] pc_plus4;
    logic            reg_write;
    result_sel_t     result_sel;
  } mw_t;

endpackage

`default_nettype wire

// File: logic/register_file.sv
`default_nettype none
`timescale 1ns/100ps

module register_file (
  input  logic                             clk,
  input  logic                             rstn,
  input  logic                             we,
  input  logic [rv_isa_pkg::REG_IDX_W-1:0] waddr,
  input  logic [pipe_pkg::XLEN-1:0]        wdata,
  input  logic [rv_isa_pkg::REG_IDX_W-1:0] raddr1,
  input  logic [rv_isa_pkg::REG_IDX_W-1:0] raddr2,
  output logic [pipe_pkg::XLEN-1:0]        rdata1,
  output logic [pipe_pkg::XLEN-1:0]        rdata2
);

  logic [pipe_pkg::XLEN-1:0] regs [32];

  always_ff @(posedge clk) begin
    if (!rstn) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (we && waddr != '0) begin
      regs[waddr] <= wdata;
    end
  end

  // W writes and D reads in the same cycle
  assign rdata1 = (raddr1 == '0) ? '0 : (we && waddr == raddr1) ? wdata : regs[raddr1];
  assign rdata2 = (raddr2 == '0) ? '0 : (we && waddr == raddr2) ? wdata : regs[raddr2];

endmodule

`default_nettype wire

// File: logic/rv_isa_pkg.sv
`default_nettype none

package rv_isa_pkg;

  localparam int REG_IDX_W = 5;

  // instruction field positions
  localparam int RD_LSB  = 7;
  localparam int F3_LSB  = 12;
  localparam int RS1_LSB = 15;
  localparam int RS2_LSB = 20;
  localparam int F7_LSB  = 25;

  // bit 30 of the word, sub vs add
  localparam int F7_SUB_BIT = 5;

  localparam logic [6:0] OP_LUI    = 7'b0110111;
  localparam logic [6:0] OP_JAL    = 7'b1101111;
  localparam logic [6:0] OP_BRANCH = 7'b1100011;
  localparam logic [6:0] OP_LOAD   = 7'b0000011;
  localparam logic [6:0] OP_STORE  = 7'b0100011;
  localparam logic [6:0] OP_IMM    = 7'b0010011;
  localparam logic [6:0] OP_REG    = 7'b0110011;

  localparam logic [2:0] F3_ADD  = 3'b000;
  localparam logic [2:0] F3_SLL  = 3'b001;
  localparam logic [2:0] F3_SLT  = 3'b010;
  localparam logic [2:0] F3_XOR  = 3'b100;
  localparam logic [2:0] F3_SRL  = 3'b101;
  localparam logic [2:0] F3_OR   = 3'b110;
  localparam logic [2:0] F3_AND  = 3'b111;
  localparam logic [2:0] F3_BEQ  = 3'b000;
  localparam logic [2:0] F3_BNE  = 3'b001;
  localparam logic [2:0] F3_WORD = 3'b010;

  typedef enum logic [2:0] {
    IMM_I,
    IMM_S,
    IMM_B,
    IMM_J,
    IMM_U
  } imm_kind_t;

endpackage

`default_nettype wire

// File: logic/stage_reg.sv
`default_nettype none
`timescale 1ns/100ps

module stage_reg #(
  parameter type payload_t = logic
) (
  input  logic     clk,
  input  logic     rstn,
  input  logic     en,
  input  logic     clr,
  input  payload_t d,
  output payload_t q
);

  // a cleared payload is a bubble
  always_ff @(posedge clk) begin
    if (!rstn) begin
      q <= '0;
    end else if (en) begin
      if (clr) begin
        q <= '0;
      end else begin
        q <= d;
      end
    end
  end

endmodule

`default_nettype wire

// File: pipe_core.f
+incdir+verification
logic/rv_isa_pkg.sv
logic/pipe_pkg.sv
logic/stage_reg.sv
logic/fetch_unit.sv
logic/decoder.sv
logic/register_file.sv
logic/hazard_unit.sv
logic/execute_unit.sv
logic/pipe_core.sv
verification/pipe_core_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# builds the pipe_core testbench with Verilator and runs it
# exit status is nonzero when the simulation fails

cd "$(dirname "$0")" &&
verilator --binary -j 0 \
  --top-module pipe_core_tb \
  -f pipe_core.f \
  -o pipe_core_sim &&
./obj_dir/pipe_core_sim ||
{ echo "build or simulation failed"; exit 1; }

exit 0

// File: verification/pipe_core_programs.svh
`ifndef PIPE_CORE_PROGRAMS_SVH
`define PIPE_CORE_PROGRAMS_SVH

localparam int NUM_PROGS  = 5;
localparam int NUM_INSTR  = 59;
localparam int NUM_STORES = 18;

// rows 3 and 4 rerun programs 0 and 2 with random data_stall
localparam int PROG_BASE [NUM_PROGS] = '{0, 29, 42, 0, 42};
localparam int PROG_LEN  [NUM_PROGS] = '{29, 13, 17, 29, 17};
localparam int EXP_BASE  [NUM_PROGS] = '{0, 8, 13, 0, 13};
localparam int EXP_LEN   [NUM_PROGS] = '{8, 5, 5, 8, 5};
localparam bit PROG_STALL [NUM_PROGS] = '{1'b0, 1'b0, 1'b0, 1'b1, 1'b1};

localparam logic [31:0] PROG_INSTR [NUM_INSTR] = '{
  // program 0: dependent alu chain, x0 write, immediate forms
  32'h00500093, 32'h00c00113, 32'h002081b3, 32'h00302023,
  32'h40118233, 32'h003262b3, 32'h0022f333, 32'h001343b3,
  32'h00702223, 32'h0040a433, 32'h001094b3, 32'h0084d533,
  32'h00a02423, 32'h123455b7, 32'h00700013, 32'h40100633,
  32'h00b02623, 32'h00c02823, 32'hffc62693, 32'h00c5d713,
  32'h01c1f793, 32'h0306e813, 32'h00f708b3, 32'hfff84913,
  32'h00309993, 32'h01102a23, 32'h01202c23, 32'h01302e23,
  32'h0000006f,
  // program 1: load-use on rs1 and rs2, jal link at 0x1c
  32'h12300093, 32'h02102023, 32'h02002103, 32'h00110193,
  32'h02302223, 32'h02402203, 32'h02402423, 32'h008002ef,
  32'h02102623, 32'h02502823, 32'h00528333, 32'h02602a23,
  32'h0000006f,
  // program 2: beq/bne both ways, then a counted loop
  32'h00300093, 32'h00300113, 32'h00400193, 32'h00308463,
  32'h00102023, 32'h00202223, 32'h00209463, 32'h00302423,
  32'h00208463, 32'h00302623, 32'h00309463, 32'h00302823,
  32'h00202a23, 32'h00120213, 32'hfe321ee3, 32'h00402c23,
  32'h0000006f
};

// {address, data} in store order
localparam logic [63:0] EXP_STORE [NUM_STORES] = '{
  // program 0
  64'h00000000_00000011, 64'h00000004_00000009,
  64'h00000008_00000050, 64'h0000000c_12345000,
  64'h00000010_fffffffb, 64'h00000014_00012355,
  64'h00000018_ffffffce, 64'h0000001c_00000028,
  // program 1
  64'h00000020_00000123, 64'h00000024_00000124,
  64'h00000028_00000124, 64'h00000030_00000020,
  64'h00000034_00000040,
  // program 2, the skipped stores to 0x0c and 0x10 must not show
  64'h00000000_00000003, 64'h00000004_00000003,
  64'h00000008_00000004, 64'h00000014_00000003,
  64'h00000018_00000004
};

`endif

// File: verification/pipe_core_tb.sv
`default_nettype none
`timescale 1ns/100ps

module pipe_core_tb;

  `include "pipe_core_programs.svh"

  logic        clk = 1'b0;
  logic        rstn = 1'b0;
  logic        data_stall = 1'b0;
  logic [31:0] imem_addr;
  logic [31:0] imem_data;
  logic [31:0] dmem_addr;
  logic [31:0] dmem_wdata;
  logic [31:0] dmem_rdata;
  logic        dmem_we;
  logic        dmem_re;

  logic [31:0] rom [64];
  logic [31:0] ram [64];
  logic        stall_en;
  int          prog;
  int          store_idx;
  int          seed;
  int          cycle_limit;
  int          cycles = 0;

  always #2 clk = ~clk;

  assign imem_data  = rom[imem_addr[7:2]];
  // reads return zero unless the core asks for them
  assign dmem_rdata = dmem_re ? ram[dmem_addr[7:2]] : 32'h0;

  pipe_core u_pipe_core (
    .clk(clk), .rstn(rstn), .imem_addr(imem_addr), .imem_data(imem_data),
    .dmem_addr(dmem_addr), .dmem_wdata(dmem_wdata), .dmem_we(dmem_we),
    .dmem_re(dmem_re), .dmem_rdata(dmem_rdata), .data_stall(data_stall)
  );

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("sim failed");
    $fatal(1);
  endtask

  task automatic compare_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
    if (got !== expected) begin
      abort_run($sformatf("[FAIL] %s got %h expected %h", name, got, expected));
    end
  endtask

  // unused words have a zero opcode and decode as no-ops
  task automatic load_program(input int p);
    for (int i = 0; i < 64; i++) begin
      if (i < PROG_LEN[p]) begin
        rom[i] <= PROG_INSTR[PROG_BASE[p] + i];
      end else begin
        rom[i] <= {i[24:0], 7'b0};
      end
      ram[i] <= {i[15:0], ~i[15:0]};
    end
  endtask

  // a store counts only on an edge where the bus is not stalled
  always @(posedge clk) begin
    if (rstn && dmem_we && !data_stall) begin
      ram[dmem_addr[7:2]] <= dmem_wdata;
      if (store_idx >= EXP_LEN[prog]) begin
        abort_run($sformatf("program %0d made an extra store to address %h", prog, dmem_addr));
      end else begin
        compare_value("dmem_addr", dmem_addr, EXP_STORE[EXP_BASE[prog] + store_idx][63:32]);
        compare_value("dmem_wdata", dmem_wdata, EXP_STORE[EXP_BASE[prog] + store_idx][31:0]);
        store_idx <= store_idx + 1;
      end
    end
  end

  always @(posedge clk) begin
    if (stall_en) begin
      data_stall <= ($random(seed) & 3) == 0;
    end else begin
      data_stall <= 1'b0;
    end
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= cycle_limit) begin
      abort_run($sformatf("timeout in program %0d, only %0d of %0d stores seen",
                          prog, store_idx, EXP_LEN[prog]));
    end
  end

  initial begin
    seed = 29;
    stall_en = 1'b0;
    prog = 0;
    store_idx = 0;
    cycle_limit = 60 * NUM_PROGS;
    for (int p = 0; p < NUM_PROGS; p++) begin
      cycle_limit += 10 * PROG_LEN[p];
    end
    load_program(0);
    for (int p = 0; p < NUM_PROGS; p++) begin
      @(posedge clk);
      rstn      <= 1'b0;
      prog      <= p;
      store_idx <= 0;
      stall_en  <= PROG_STALL[p];
      load_program(p);
      repeat (2) @(posedge clk);
      // core outputs sit at their reset values
      compare_value("imem_addr", imem_addr, 32'h0);
      compare_value("dmem_we", {31'b0, dmem_we}, 32'h0);
      compare_value("dmem_re", {31'b0, dmem_re}, 32'h0);
      rstn <= 1'b1;
      while (store_idx < EXP_LEN[p]) begin
        @(posedge clk);
      end
      // the self loop must stay quiet
      repeat (20) @(posedge clk);
    end
    $display("sim passed");
    $finish;
  end

endmodule

`default_nettype wire
